/* gpio_bus_slave.f */
+incdir+include
design/gpio_slave_pkg.sv
design/bus_decode.sv
design/wait_state_timer.sv
design/gpo_bank.sv
design/read_response.sv
design/gpio_bus_slave.sv
sim/clock_reset_gen.sv
sim/tb_gpio_bus_slave.sv

/* run_sim.sh */
#!/bin/sh
# Build the GPIO bus slave testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
	-f gpio_bus_slave.f \
	--top-module tb_gpio_bus_slave \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_gpio_bus_slave > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
	exit 1
fi
if ! grep -q "TESTS PASSED" "$log"; then
	echo "Simulation log has no final result"
	exit 1
fi
exit 0

/* sim/tb_gpio_bus_slave.sv */
/*
  Testbench of the GPIO bus slave.
  Applies a table of bus accesses (GPO writes and read-back, GPI reads,
  illegal accesses) one at a time, with inputs driven 2 ns after the
  clock edge. Expected values come from a shadow of the GPO bank and
  from the random GPI pattern. Run through run_sim.sh.
*/
`timescale 1ns/1ps
`include "gpio_slave_config.svh"

module tb_gpio_bus_slave;

	localparam int clk_period_ns = 40;
	localparam int reset_cycles  = 3;
	localparam int max_edges     = 8;              // Longest wait for ready
	localparam logic [31:0] gpio_base = 32'h0100_0000;

	// One bus access and what it should produce
	typedef struct packed {
		logic        rnw;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        exp_error;
		logic        chk_data;  // read_data holds a fresh word
	} vector_t;

	logic                    BUS;
	logic                    arst_n;
	logic [`GPIO_ADDR_W-1:0] addr;
	logic                    rnw;
	logic [`GPIO_DATA_W-1:0] write_data;
	logic                    valid;
	logic                    ready;
	logic                    error;
	logic [`GPIO_DATA_W-1:0] read_data;
	logic [`GPIO_PORT_W-1:0] gp_ip;
	logic [`GPIO_PORT_W-1:0] gp_op;
	logic [`GPIO_WORDS-1:0]  gp_op_valid;

	vector_t     vectors[$];
	logic [31:0] shadow [8];    // Expected GPO words
	logic [31:0] gpi_words [8]; // Pattern on gp_ip
	logic [31:0] last_read;     // read_data is kept between reads
	logic [31:0] seed_ret;
	int          table_len   = 0;
	int          error_count = 0;
	int          tests_run   = 0;
	int          tests_bad   = 0;

	clock_reset_gen #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) u_clkgen (
		.BUS    (BUS),
		.arst_n (arst_n)
	);

	gpio_bus_slave DUT (
		.BUS         (BUS),
		.arst_n      (arst_n),
		.addr        (addr),
		.rnw         (rnw),
		.write_data  (write_data),
		.valid       (valid),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gp_ip       (gp_ip),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// Table and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic void add_vector(input logic r, input logic [31:0] a,
		input logic [31:0] d, input logic e, input logic c);
		vector_t v;
		v.rnw       = r;
		v.addr      = a;
		v.wdata     = d;
		v.exp_error = e;
		v.chk_data  = c;
		vectors.push_back(v);
	endfunction

	function automatic void build_table();
		for (int w = 0; w < 8; w++) begin
			add_vector(1'b0, gpio_base + 32'(w * 4), $urandom(), 1'b0, 1'b0); // GPO writes
		end
		for (int w = 0; w < 8; w++) begin
			add_vector(1'b1, gpio_base + 32'(w * 4), 32'h0, 1'b0, 1'b1);      // Read-back
		end
		for (int w = 0; w < 8; w++) begin
			add_vector(1'b1, gpio_base + 32'h20 + 32'(w * 4), 32'h0, 1'b0, 1'b1); // GPI
		end
		add_vector(1'b0, gpio_base + 32'h20, $urandom(), 1'b1, 1'b0); // Write to GPI
		add_vector(1'b0, gpio_base + 32'h3c, $urandom(), 1'b1, 1'b0);
		add_vector(1'b1, gpio_base + 32'h40, 32'h0, 1'b1, 1'b0);      // Past GPI
		add_vector(1'b0, gpio_base + 32'h40, $urandom(), 1'b1, 1'b0);
		add_vector(1'b1, gpio_base + 32'hfc, 32'h0, 1'b1, 1'b0);      // Top of page
		add_vector(1'b1, 32'h0200_0000, 32'h0, 1'b1, 1'b0);           // Foreign page
		add_vector(1'b0, 32'h0000_0004, $urandom(), 1'b1, 1'b0);
		add_vector(1'b1, gpio_base + 32'h02, 32'h0, 1'b1, 1'b0);      // Unaligned
		add_vector(1'b0, gpio_base + 32'h05, $urandom(), 1'b1, 1'b0);
		add_vector(1'b1, gpio_base + 32'h23, 32'h0, 1'b1, 1'b0);
		add_vector(1'b0, gpio_base + 32'h0c, $urandom(), 1'b0, 1'b0); // Overwrite word 3
		add_vector(1'b1, gpio_base + 32'h0c, 32'h0, 1'b0, 1'b1);
		add_vector(1'b1, gpio_base + 32'h00, 32'h0, 1'b0, 1'b1);
	endfunction

	// Bit 5 of the offset picks GPI and bits 4:2 the word
	function automatic logic [31:0] expected_read(input logic [31:0] a);
		if (a[5]) begin
			return gpi_words[a[4:2]];
		end
		return shadow[a[4:2]];
	endfunction

	function automatic logic [255:0] shadow_bits();
		logic [255:0] r;
		for (int w = 0; w < 8; w++) begin
			r[w*32 +: 32] = shadow[w];
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// One access entered and left 2 ns after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic run_vector(input int n);
		vector_t      v;
		int           edges;
		int           want_edges;
		int           errs_before;
		logic         got_ready;
		logic [31:0]  exp_data;
		logic [7:0]   exp_valid;
		logic [255:0] exp_op;

		v           = vectors[n];
		errs_before = error_count;
		exp_valid   = 8'h00;
		if (!v.rnw && !v.exp_error) begin
			shadow[v.addr[4:2]] = v.wdata; // Legal write lands in the shadow
			exp_valid = 8'b1 << v.addr[4:2];
		end
		exp_op     = shadow_bits();
		exp_data   = v.chk_data ? expected_read(v.addr) : last_read;
		want_edges = v.rnw ? `GPIO_READ_WAIT : `GPIO_WRITE_WAIT;

		addr       = v.addr;
		rnw        = v.rnw;
		write_data = v.wdata;
		valid      = 1'b1;

		edges     = 0;
		got_ready = 1'b0;
		while (!got_ready && edges < max_edges) begin
			@(posedge BUS);
			#1;
			edges++;
			if (ready) begin
				got_ready = 1'b1;
			end
			else if (gp_op_valid != 8'h00) begin // No pulse while waiting
				$display("Fail gp_op_valid before ready: got 0x%02h expected 0x00",
					gp_op_valid);
				error_count++;
			end
		end

		if (!got_ready) begin
			$display("Error: no ready within %0d edges of valid in test %0d", max_edges, n);
			error_count++;
		end
		else begin
			if (edges != want_edges) begin
				$display("Fail ready latency: got 0x%0h edges expected 0x%0h", edges, want_edges);
				error_count++;
			end
			if (error != v.exp_error) begin
				$display("Fail error: got 0x%0h expected 0x%0h", error, v.exp_error);
				error_count++;
			end
			if (read_data != exp_data) begin
				$display("Fail read_data: got 0x%08h expected 0x%08h", read_data, exp_data);
				error_count++;
			end
			if (gp_op_valid != exp_valid) begin
				$display("Fail gp_op_valid: got 0x%02h expected 0x%02h", gp_op_valid, exp_valid);
				error_count++;
			end
			if (gp_op != exp_op) begin
				$display("Fail gp_op: got 0x%064h expected 0x%064h", gp_op, exp_op);
				error_count++;
			end
		end

		#1;
		valid = 1'b0; // Master drops valid after sampling ready
		@(posedge BUS);
		#1;
		if (ready) begin // Pulse is one cycle wide
			$display("Fail ready after pulse: got 0x%0h expected 0x0", ready);
			error_count++;
		end
		if (gp_op_valid != 8'h00) begin
			$display("Fail gp_op_valid after pulse: got 0x%02h expected 0x00",
				gp_op_valid);
			error_count++;
		end
		#1;

		last_read = exp_data;
		tests_run++;
		if (error_count != errs_before) begin
			tests_bad++;
		end
		$display("test %0d %s 0x%08h %s", n, v.rnw ? "read " : "write", v.addr,
			(error_count == errs_before) ? "ok" : "fail");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed_ret   = $urandom(32'hd247);
		valid      = 1'b0;
		rnw        = 1'b1;
		addr       = '0;
		write_data = '0;
		last_read  = 32'h0;
		for (int w = 0; w < 8; w++) begin
			gpi_words[w]       = $urandom();
			gp_ip[w*32 +: 32] = gpi_words[w];
			shadow[w]         = 32'h0; // Bank is clear after reset
		end
		build_table();
		table_len = vectors.size();

		wait (arst_n === 1'b1);
		@(posedge BUS);
		#1;
		if (ready) begin
			$display("Fail ready after reset: got 0x%0h expected 0x0", ready);
			error_count++;
		end
		if (error) begin
			$display("Fail error after reset: got 0x%0h expected 0x0", error);
			error_count++;
		end
		if (gp_op_valid != 8'h00) begin
			$display("Fail gp_op_valid after reset: got 0x%02h expected 0x00", gp_op_valid);
			error_count++;
		end
		if (gp_op != '0) begin
			$display("Fail gp_op after reset: got 0x%064h expected 0x0", gp_op);
			error_count++;
		end
		if (read_data != '0) begin
			$display("Fail read_data after reset: got 0x%08h expected 0x0", read_data);
			error_count++;
		end
		if (error_count != 0) begin
			tests_bad++;
		end
		tests_run++;
		$display("test reset %s", (error_count == 0) ? "ok" : "fail");
		#1;

		for (int i = 0; i < table_len; i++) begin
			run_vector(i);
		end

		$display("%0d tests, %0d ok, %0d failed, %0d check errors",
			tests_run, tests_run - tests_bad, tests_bad, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog allows twice the worst case per entry plus reset
	initial begin
		int watchdog_ns;
		wait (table_len != 0);
		watchdog_ns = table_len * max_edges * clk_period_ns * 2
			+ (reset_cycles + 4) * clk_period_ns;
		#(watchdog_ns);
		$display("Watchdog: run did not finish within %0d ns", watchdog_ns);
		$display("TESTS FAILED");
		$finish;
	end

endmodule : tb_gpio_bus_slave

/* sim/clock_reset_gen.sv */
/*
  Testbench clock and reset for the GPIO bus slave.
  Free-running clock, reset held low for a few cycles and released
  just after a rising edge.
*/
`timescale 1ns/1ps

module clock_reset_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 3
) (
	output logic BUS,
	output logic arst_n
);

	initial begin
		BUS = 1'b0;
		forever #(period_ns / 2) BUS = ~BUS;
	end

	// Release off the edge so no flop sees it change at the edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge BUS);
		#2 arst_n = 1'b1;
	end

endmodule : clock_reset_gen

/* design/gpio_bus_slave.sv */
/*
  GPIO bus slave, top level.
  Valid/ready bus slave with eight GPO words (offsets 0x00-0x1C, r/w)
  and eight GPI words (0x20-0x3C, read only) at base 0x0100_0000.
  Writes answer on the 3rd edge after valid, reads on the 4th.
  Stages: decode, wait-state timer, GPO bank, read/response.
*/
`timescale 1ns/1ps
`include "gpio_slave_config.svh"

module gpio_bus_slave (
	// Clock and reset
	input  logic                    BUS,
	input  logic                    arst_n,

	// Bus, master side
	input  logic [`GPIO_ADDR_W-1:0] addr,
	input  logic                    rnw,        // 1 = read, 0 = write
	input  logic [`GPIO_DATA_W-1:0] write_data,
	input  logic                    valid,      // Held until ready is sampled

	// Bus, slave side
	output logic                    ready,      // One-cycle pulse
	output logic                    error,      // Qualified by ready
	output logic [`GPIO_DATA_W-1:0] read_data,  // Qualified by ready on reads

	// GPIO pins
	input  logic [`GPIO_PORT_W-1:0] gp_ip,
	output logic [`GPIO_PORT_W-1:0] gp_op,
	output logic [`GPIO_WORDS-1:0]  gp_op_valid
);

	import gpio_slave_pkg::*;

	access_region_t           region;      // Decode result
	logic [`GPIO_INDEX_W-1:0] word_index;  // Word within bank
	logic                     addr_ok;     // Access is legal
	logic                     access_done; // Timer strobe

	//////////////////////////////////////////////////////////////////////
	// Stage 1, decode
	//////////////////////////////////////////////////////////////////////

	bus_decode u_decode (
		.addr       (addr),  // Raw word into the address union
		.rnw        (rnw),
		.region     (region),
		.word_index (word_index),
		.addr_ok    (addr_ok)
	);

	//////////////////////////////////////////////////////////////////////
	// Stage 2, wait states
	//////////////////////////////////////////////////////////////////////

	wait_state_timer u_timer (
		.BUS         (BUS),
		.arst_n      (arst_n),
		.valid       (valid),
		.rnw         (rnw),
		.access_done (access_done)
	);

	// Stage 3, output bank
	gpo_bank u_gpo (
		.BUS         (BUS),
		.arst_n      (arst_n),
		.access_done (access_done),
		.rnw         (rnw),
		.addr_ok     (addr_ok),
		.word_index  (word_index),
		.write_data  (write_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	// Stage 4, response
	read_response u_resp (
		.BUS         (BUS),
		.arst_n      (arst_n),
		.access_done (access_done),
		.rnw         (rnw),
		.addr_ok     (addr_ok),
		.region      (region),
		.word_index  (word_index),
		.gp_op       (gp_op),       // Read-back of the bank
		.gp_ip       (gp_ip),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data)
	);

endmodule : gpio_bus_slave

/* design/read_response.sv */
/*
  Stage 4 of the GPIO slave, read data and response.
  On the access strobe it registers a one-cycle ready, the error flag
  and, for a legal read, the GPO or GPI word picked by region and index.
  read_data holds its last value on writes and errors.
*/
`timescale 1ns/1ps
`include "gpio_slave_config.svh"

module read_response (
	input  logic                           BUS,
	input  logic                           arst_n,
	input  logic                           access_done,
	input  logic                           rnw,
	input  logic                           addr_ok,
	input  gpio_slave_pkg::access_region_t region,
	input  logic [`GPIO_INDEX_W-1:0]       word_index,
	input  logic [`GPIO_PORT_W-1:0]        gp_op,      // Bank contents for read-back
	input  logic [`GPIO_PORT_W-1:0]        gp_ip,      // Input pins, sampled here
	output logic                           ready,
	output logic                           error,
	output logic [`GPIO_DATA_W-1:0]        read_data
);

	import gpio_slave_pkg::*;

	logic [`GPIO_DATA_W-1:0] gpo_word; // Selected output word
	logic [`GPIO_DATA_W-1:0] gpi_word; // Selected input word
	logic [`GPIO_DATA_W-1:0] rd_word;  // Word returned for this read
	logic                    rd_load;  // Legal read completes

	//////////////////////////////////////////////////////////////////////
	// Word select
	//////////////////////////////////////////////////////////////////////

	assign gpo_word = gp_op[word_index*`GPIO_DATA_W +: `GPIO_DATA_W];
	assign gpi_word = gp_ip[word_index*`GPIO_DATA_W +: `GPIO_DATA_W];

	// Only GPO or GPI can reach here with addr_ok set
	assign rd_word = (region == REGION_GPI) ? gpi_word : gpo_word;
	assign rd_load = access_done && rnw && addr_ok;

	//////////////////////////////////////////////////////////////////////
	// Response registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS or negedge arst_n) begin
		if (!arst_n) begin
			ready <= 1'b0;
			error <= 1'b0;
		end
		else begin
			ready <= access_done;             // Pulse, timer restarts after it
			error <= access_done && !addr_ok; // Valid only alongside ready
		end
	end

	always_ff @(posedge BUS or negedge arst_n) begin
		if (!arst_n) begin
			read_data <= '0;
		end
		else if (rd_load) begin
			read_data <= rd_word; // gp_ip sampled on the ready edge
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// The master relies on a single-cycle pulse
	a_ready_pulse : assert property (
		@(posedge BUS) disable iff (!arst_n)
		ready |=> !ready
	) else $error("ready high for two cycles");

endmodule : read_response

/* design/gpo_bank.sv */
/*
  Stage 3 of the GPIO slave, the GPO register bank.
  Holds the 256 output bits as eight bus words. A legal write strobe
  loads one word and pulses its gp_op_valid bit for a single cycle,
  on the same edge that raises ready.
*/
`timescale 1ns/1ps
`include "gpio_slave_config.svh"

module gpo_bank (
	input  logic                     BUS,
	input  logic                     arst_n,
	input  logic                     access_done, // From the timer
	input  logic                     rnw,
	input  logic                     addr_ok,     // From decode
	input  logic [`GPIO_INDEX_W-1:0] word_index,
	input  logic [`GPIO_DATA_W-1:0]  write_data,
	output logic [`GPIO_PORT_W-1:0]  gp_op,       // Output pins
	output logic [`GPIO_WORDS-1:0]   gp_op_valid  // Per-word update pulse
);

	logic                   wr_strobe; // Legal write completes this cycle
	logic [`GPIO_WORDS-1:0] word_sel;  // One-hot word enable

	// A legal write is always GPO, decode already rejected GPI writes
	assign wr_strobe = access_done && !rnw && addr_ok;

	always_comb begin
		word_sel = '0;
		word_sel[word_index] = wr_strobe;
	end

	//////////////////////////////////////////////////////////////////////
	// Output words and pulses
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS or negedge arst_n) begin
		if (!arst_n) begin
			gp_op       <= '0;
			gp_op_valid <= '0;
		end
		else begin
			gp_op_valid <= word_sel; // High for one cycle only
			for (int w = 0; w < `GPIO_WORDS; w++) begin
				if (word_sel[w]) begin
					gp_op[w*`GPIO_DATA_W +: `GPIO_DATA_W] <= write_data;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// At most one word updates per access
	a_op_valid_onehot : assert property (
		@(posedge BUS) disable iff (!arst_n)
		$onehot0(gp_op_valid)
	) else $error("gp_op_valid not one-hot");

	// A pulse traces back to a legal write strobe and does not linger
	a_op_valid_pulse : assert property (
		@(posedge BUS) disable iff (!arst_n)
		|gp_op_valid |-> $past(wr_strobe) ##1 (gp_op_valid == '0)
	) else $error("gp_op_valid without a write or longer than a cycle");

endmodule : gpo_bank

/* design/wait_state_timer.sv */
/*
  Stage 2 of the GPIO slave, wait-state timer.
  Counts edges while valid is held and strobes access_done in the cycle
  before the edge that answers (edge 3 for writes, edge 4 for reads).
  Dropping valid aborts the access and clears the count.
*/
`timescale 1ns/1ps
`include "gpio_slave_config.svh"

module wait_state_timer (
	input  logic BUS,        // Bus clock
	input  logic arst_n,
	input  logic valid,      // Level held by master
	input  logic rnw,        // Picks the wait length
	output logic access_done // One cycle, consumed on the next edge
);

	logic [1:0] wait_cnt; // Edges seen with valid high
	logic [1:0] last_cnt; // Count at which the access completes

	//////////////////////////////////////////////////////////////////////
	// Terminal count
	//////////////////////////////////////////////////////////////////////

	// Response is registered, so the strobe fires one count early
	assign last_cnt = rnw ? 2'(`GPIO_READ_WAIT - 1) : 2'(`GPIO_WRITE_WAIT - 1);

	assign access_done = valid && (wait_cnt == last_cnt);

	//////////////////////////////////////////////////////////////////////
	// Counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS or negedge arst_n) begin
		if (!arst_n) begin
			wait_cnt <= 2'd0;
		end
		else if (!valid) begin
			wait_cnt <= 2'd0; // Idle or aborted access
		end
		else if (access_done) begin
			wait_cnt <= 2'd0; // Restart so a held valid begins the next access
		end
		else begin
			wait_cnt <= wait_cnt + 2'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Strobe only once valid was held over every earlier edge of the wait
	a_done_after_wait : assert property (
		@(posedge BUS) disable iff (!arst_n)
		access_done |-> $past(valid, 1) && $past(valid, `GPIO_WRITE_WAIT - 1)
			&& (!rnw || $past(valid, `GPIO_READ_WAIT - 1))
	) else $error("access_done before valid was held for the wait");

endmodule : wait_state_timer

/* design/bus_decode.sv */
/*
  Stage 1 of the GPIO slave, address decode.
  Purely combinational: splits the held bus address into region and
  word index and flags whether the access is legal for its direction.
*/
`timescale 1ns/1ps
`include "gpio_slave_config.svh"

module bus_decode (
	input  gpio_slave_pkg::bus_addr_u      addr,       // Held by master while valid
	input  logic                           rnw,        // 1 = read
	output gpio_slave_pkg::access_region_t region,
	output logic [`GPIO_INDEX_W-1:0]       word_index,
	output logic                           addr_ok
);

	import gpio_slave_pkg::*;

	logic       page_ok;     // Upper address bits hit our page
	logic       aligned;     // Byte lane is zero
	logic [7:0] offset_base; // In-page offset with index and lane stripped

	//////////////////////////////////////////////////////////////////////
	// Address fields
	//////////////////////////////////////////////////////////////////////

	assign page_ok     = (addr.raw[`GPIO_ADDR_W-1:8] == `GPIO_PAGE);
	assign aligned     = (addr.fields.byte_lane == 2'b00);
	assign offset_base = {addr.fields.upper, addr.fields.region_sel, 5'd0};
	assign word_index  = addr.fields.word_index; // Same slot in both banks

	//////////////////////////////////////////////////////////////////////
	// Region select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (!page_ok) begin
			region = REGION_NONE; // Foreign page
		end
		else if (offset_base == `GPIO_GPO_OFFSET) begin
			region = REGION_GPO;
		end
		else if (offset_base == `GPIO_GPI_OFFSET) begin
			region = REGION_GPI;
		end
		else begin
			region = REGION_NONE; // Above 0x3C in the page
		end
	end

	// Legality per direction
	// GPO is read/write, GPI read only, everything must be word aligned
	always_comb begin
		case (region)
			REGION_GPO: addr_ok = aligned;
			REGION_GPI: addr_ok = aligned && rnw; // Writes to inputs are errors
			default:    addr_ok = 1'b0;
		endcase
	end

endmodule : bus_decode

/* design/gpio_slave_pkg.sv */
/*
  Shared types of the GPIO bus slave.
  The address union gives the raw bus word and its page/offset split;
  the region enum carries the decode result between the stages.
*/
`include "gpio_slave_config.svh"

package gpio_slave_pkg;

	// Field view of a bus address, MSB first
	typedef struct packed {
		logic [`GPIO_ADDR_W-9:0]  page;       // Must match GPIO_PAGE
		logic [1:0]               upper;      // Zero for both banks
		logic                     region_sel; // 0 = GPO, 1 = GPI
		logic [`GPIO_INDEX_W-1:0] word_index; // Word within the bank
		logic [1:0]               byte_lane;  // Nonzero means unaligned
	} bus_addr_fields_t;

	// One address word, read raw or as fields
	typedef union packed {
		logic [`GPIO_ADDR_W-1:0] raw;
		bus_addr_fields_t        fields;
	} bus_addr_u;

	// Decoded target of an access
	typedef enum logic [1:0] {
		REGION_GPO  = 2'b00,
		REGION_GPI  = 2'b01,
		REGION_NONE = 2'b11
	} access_region_t;

endpackage : gpio_slave_pkg

/* include/gpio_slave_config.svh */
/*
  Address map, widths and wait counts of the GPIO bus slave.
  Included by the package and by every module that sizes ports or
  compares against the map. Change the map here only.
*/
`ifndef GPIO_SLAVE_CONFIG_SVH
`define GPIO_SLAVE_CONFIG_SVH

// Bus widths
`define GPIO_DATA_W 32
`define GPIO_ADDR_W 32

// Bank geometry, eight 32-bit words per direction
`define GPIO_WORDS 8
`define GPIO_INDEX_W 3
`define GPIO_PORT_W 256

// Page above address bit 8, base 0x0100_0000
`define GPIO_PAGE 24'h010000

// Region starts within the page
`define GPIO_GPO_OFFSET 8'h00
`define GPIO_GPI_OFFSET 8'h20

// Edges from first sampled valid up to the edge that raises ready
`define GPIO_WRITE_WAIT 3
`define GPIO_READ_WAIT 4

`endif
